// ==== verilog.f ====
+incdir+design
design/rv_decode_pkg.sv
design/op_decoder.sv
design/imm_gen.sv
design/operand_forward.sv
design/hazard_unit.sv
design/decode_stage.sv
bench/decode_stage_properties.sv
bench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: rv_decode_stage

export_include_dirs:
  - design

sources:
  - files:
      - design/rv_decode_pkg.sv
      - design/op_decoder.sv
      - design/imm_gen.sv
      - design/operand_forward.sv
      - design/hazard_unit.sv
      - design/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_properties.sv
      - bench/decode_stage_tb.sv

// ==== bench/decode_stage_tb.sv ====
////////////////////////////////////////////////////////////
// Table driven testbench for the decode stage
// Register bank model returns n * 0x01010101 for address n
// Stops at the first mismatch
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

module decode_stage_tb;
    import rv_decode_pkg::*;

    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
        logic [2:0]          ctl;      // Flush, enable, access fault
        fwd_t                fwd;
        op_e                 op;
        logic                hazard;   // Expected on first issue
        logic [`RV_XLEN-1:0] rs1;
        logic [`RV_XLEN-1:0] rs2;
        logic [`RV_XLEN-1:0] second;
        logic [`RV_XLEN-1:0] target;
        exc_t                exc;
    } step_t;

    localparam logic [2:0] ctl_run   = 3'b010;
    localparam logic [2:0] ctl_fault = 3'b011;
    localparam logic [2:0] ctl_flush = 3'b111;   // Fault set too, must be masked
    localparam logic [2:0] ctl_hold  = 3'b000;
    localparam fwd_t       no_fwd    = '0;
    localparam int         drive_delay  = 2;
    localparam int         hazard_limit = 4;
    localparam int         reset_limit  = 20;

    logic                  clk;
    logic                  reset_n;
    logic                  enable;
    logic                  flush;
    fetch_t                fetch;
    logic [`RV_XLEN-1:0]   rs1_rdata;
    logic [`RV_XLEN-1:0]   rs2_rdata;
    fwd_t                  fwd;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic                  hazard;
    decoded_t              decoded;
    step_t                 steps[$];

    decode_stage dut_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable),
        .flush_i     (flush),
        .fetch_i     (fetch),
        .rs1_rdata_i (rs1_rdata),
        .rs2_rdata_i (rs2_rdata),
        .fwd_i       (fwd),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .hazard_o    (hazard),
        .decoded_o   (decoded)
    );

    function automatic logic [`RV_XLEN-1:0] bank(input logic [`RV_REG_AW-1:0] n);
        return 32'(n) * 32'h0101_0101;
    endfunction

    assign rs1_rdata = bank(rs1_addr);   // Same cycle read
    assign rs2_rdata = bank(rs2_addr);

    function automatic fwd_t make_fwd(input logic ex_we, input logic [31:0] ex_data,
                                      input logic wb_we, input logic [4:0] wb_rd,
                                      input logic [31:0] wb_data);
        fwd_t f;
        f.exec_we     = ex_we;
        f.exec_result = ex_data;
        f.wb_we       = wb_we;
        f.wb_rd       = wb_rd;
        f.wb_data     = wb_data;
        return f;
    endfunction

    task automatic add_step(input logic [31:0] instr, input logic [31:0] pc,
                            input logic [2:0] ctl, input fwd_t f, input op_e op,
                            input logic hz, input logic [31:0] rs1,
                            input logic [31:0] rs2, input logic [31:0] second,
                            input logic [31:0] target, input logic [2:0] exc);
        step_t s;
        s = {instr, pc, ctl, f, op, hz, rs1, rs2, second, target, exc};
        steps.push_back(s);
    endtask

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare(input logic [$bits(decoded_t)-1:0] actual,
                           input logic [$bits(decoded_t)-1:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s mismatch, got %0h expected %0h",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic drive(input step_t s);
        fetch.instr        = s.instr;
        fetch.pc           = s.pc;
        fetch.access_fault = s.ctl[0];
        flush              = s.ctl[2];
        enable             = s.ctl[1];
        fwd                = s.fwd;
    endtask

    task automatic check_result(input step_t s);
        compare(decoded.op, s.op, "op");
        compare(decoded.rd, s.instr[11:7], "rd");
        compare(decoded.rs1_data, s.rs1, "rs1 data");
        compare(decoded.rs2_data, s.rs2, "rs2 data");
        compare(decoded.second, s.second, "second operand");
        compare(decoded.pc, s.pc, "pc");
        compare(decoded.jump_target, s.target, "jump target");
        compare(decoded.killed, s.ctl[2], "killed");
        compare(decoded.exc, s.exc, "exception flags");
    endtask

    // Fetch replays the same word until the stall goes away
    task automatic wait_hazard_clear();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hazard) begin
            cycles++;
            if (cycles >= hazard_limit) begin
                $display("hazard_o stayed high for %0d cycles on a replay", cycles);
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > reset_limit) begin
                $display("Reset was not released within %0d cycles", reset_limit);
                stop_run();
            end
        end
        #(drive_delay);
    endtask

    task automatic run_step(input step_t s);
        decoded_t held;
        drive(s);
        @(negedge clk);                          // Combinational outputs settled
        compare(hazard, s.hazard, "hazard_o");
        compare(rs1_addr, s.instr[19:15], "rs1_addr_o");
        compare(rs2_addr, s.instr[24:20], "rs2_addr_o");
        held = decoded;
        @(posedge clk);
        #(drive_delay);
        if (!s.ctl[1]) begin
            compare(decoded, held, "held output");
        end else if (s.hazard) begin
            compare(decoded.op, NOP, "bubble op");
            compare(decoded.killed, 1'b0, "bubble killed");
            wait_hazard_clear();
            @(posedge clk);
            #(drive_delay);
            check_result(s);
        end else begin
            check_result(s);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic build_table();
        fwd_t both;
        fwd_t wb_only;
        both    = make_fwd(1'b1, 32'hAAAA_0001, 1'b1, 5'd9, 32'hBBBB_0002);
        wb_only = make_fwd(1'b1, 32'hAAAA_0001, 1'b1, 5'd9, 32'hBBBB_0002);
        // One instruction per format
        add_step(32'hFFB1_0093, 32'h100, ctl_run, no_fwd, ADD, 0, bank(2), bank(27),
                 32'hFFFF_FFFB, 32'h0FB, 3'b000);                     // ADDI x1, x2, -5
        add_step(32'h0030_A423, 32'h104, ctl_run, no_fwd, SW, 0, bank(1), bank(3),
                 32'h8, 32'h10C, 0);
        add_step(32'hFE20_88E3, 32'h108, ctl_run, no_fwd, BEQ, 0, bank(1), bank(2),
                 bank(2), 32'h0F8, 3'b000);
        add_step(32'h1234_52B7, 32'h10C, ctl_run, no_fwd, LUI, 0, bank(8), bank(3),
                 32'h1234_5000, 32'h1234_510C, 3'b000);
        add_step(32'h0000_1317, 32'h110, ctl_run, no_fwd, AUIPC, 0, 0, 0, 32'h1000,
                 32'h1110, 0);
        add_step(32'h0010_00EF, 32'h114, ctl_run, no_fwd, JAL, 0, 0, bank(1), bank(1),
                 32'h914, 0);
        add_step(32'h3001_93F3, 32'h118, ctl_run, no_fwd, CSRRW, 0, bank(3), 0, 0,
                 32'h118, 0);
        // Forwarding priority on x9
        add_step(32'h0020_84B3, 32'h11C, ctl_run, no_fwd, ADD, 0, bank(1), bank(2),
                 bank(2), 32'h11C, 0);
        add_step(32'h0004_8533, 32'h120, ctl_run, both, ADD, 0, 32'hAAAA_0001, 0, 0,
                 32'h120, 0);
        add_step(32'h0004_85B3, 32'h124, ctl_run, wb_only, ADD, 0, 32'hBBBB_0002, 0, 0,
                 32'h124, 3'b000);                                    // Execute rd is x10
        add_step(32'h0004_8633, 32'h128, ctl_run, no_fwd, ADD, 0, bank(9), 0, 0,
                 32'h128, 0);
        // Load-use, then store followed by load
        add_step(32'h0000_A683, 32'h12C, ctl_run, no_fwd, LW, 0, bank(1), 0, 0,
                 32'h12C, 0);
        add_step(32'h0026_8733, 32'h130, ctl_run, no_fwd, ADD, 1, bank(13), bank(2),
                 bank(2), 32'h130, 0);
        add_step(32'h0030_A423, 32'h134, ctl_run, no_fwd, SW, 0, bank(1), bank(3),
                 32'h8, 32'h13C, 0);
        add_step(32'h0000_A683, 32'h138, ctl_run, no_fwd, LW, 1, bank(1), 0, 0,
                 32'h138, 0);
        // Exceptions while x13 is locked
        add_step(32'h0026_8733, 32'h13E, ctl_run, no_fwd, ADD, 0, bank(13), bank(2),
                 bank(2), 32'h13E, 3'b010);
        add_step(32'h0000_A683, 32'h140, ctl_run, no_fwd, LW, 0, bank(1), 0, 0,
                 32'h140, 0);
        add_step(32'h0026_8730, 32'h144, ctl_run, no_fwd, INVALID, 0, bank(13), bank(2),
                 bank(2), 32'h144, 3'b100);                           // Low bits 00
        add_step(32'h0000_A683, 32'h148, ctl_run, no_fwd, LW, 0, bank(1), 0, 0,
                 32'h148, 0);
        add_step(32'h0006_800B, 32'h14C, ctl_run, no_fwd, INVALID, 0, bank(13), 0, 0,
                 32'h14C, 3'b100);                                    // Unused opcode
        add_step(32'h0000_A683, 32'h150, ctl_run, no_fwd, LW, 0, bank(1), 0, 0,
                 32'h150, 0);
        add_step(32'h0026_8733, 32'h154, ctl_fault, no_fwd, ADD, 0, bank(13), bank(2),
                 bank(2), 32'h154, 3'b001);
        // Flush clears the lock, then enable low holds the output
        add_step(32'h0000_A683, 32'h158, ctl_run, no_fwd, LW, 0, bank(1), 0, 0,
                 32'h158, 0);
        add_step(32'h0006_A683, 32'h15E, ctl_flush, no_fwd, NOP, 0, bank(13), 0, 0,
                 32'h15E, 3'b000);                                    // LW x13, 0(x13)
        add_step(32'h0026_8733, 32'h160, ctl_run, no_fwd, ADD, 0, bank(13), bank(2),
                 bank(2), 32'h160, 0);
        add_step(32'hFFB1_0093, 32'h164, ctl_hold, no_fwd, ADD, 0, bank(2), bank(27),
                 32'hFFFF_FFFB, 32'h15F, 3'b000);
        add_step(32'hFFB1_0093, 32'h164, ctl_run, no_fwd, ADD, 0, bank(2), bank(27),
                 32'hFFFF_FFFB, 32'h15F, 3'b000);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        #(drive_delay);
        reset_n = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        decoded_t reset_value;
        enable             = 1'b0;
        flush              = 1'b0;
        fetch.pc           = '0;
        fetch.instr        = 32'h0000_0013;   // ADDI x0, x0, 0
        fetch.access_fault = 1'b0;
        fwd                = '0;
        reset_value        = '0;
        reset_value.op     = NOP;
        build_table();
        wait_reset_release();
        compare(decoded, reset_value, "reset output");
        compare(hazard, 1'b0, "hazard_o after reset");
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== bench/decode_stage_properties.sv ====
////////////////////////////////////////////////////////////
// Concurrent checks on the decode stage outputs, bound in
// Sampled on the rising clock, quiet while reset is low
////////////////////////////////////////////////////////////

module decode_stage_properties (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    enable_i,
    input logic                    flush_i,
    input logic                    hazard_o,
    input rv_decode_pkg::decoded_t decoded_o
);
    import rv_decode_pkg::*;

    // Flush on an enabled edge gives a killed NOP
    flush_kills_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (flush_i && enable_i) |=> (decoded_o.op == NOP && decoded_o.killed)
    ) else $error("flush on an enabled edge did not give a killed NOP");

    // A stall becomes a plain NOP, so it never came with a flush
    hazard_bubble_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (hazard_o && enable_i) |=> (decoded_o.op == NOP && !decoded_o.killed)
    ) else $error("hazard_o high during a flush or without a bubble");

    // A trapping instruction is never turned into a bubble
    exc_not_bubble_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (decoded_o.exc != '0 && decoded_o.op == NOP) |-> decoded_o.killed
    ) else $error("exception flag on a NOP that is not killed");

endmodule

bind decode_stage decode_stage_properties props_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .enable_i  (enable_i),
    .flush_i   (flush_i),
    .hazard_o  (hazard_o),
    .decoded_o (decoded_o)
);

// ==== design/decode_stage.sv ====
////////////////////////////////////////////////////////////
// RV32I decode stage with one output register
// Fetch replays its word while hazard_o is high
// enable_i low freezes the output and the lock state
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     enable_i,
    input  logic                     flush_i,
    input  rv_decode_pkg::fetch_t    fetch_i,
    input  logic [`RV_XLEN-1:0]      rs1_rdata_i,
    input  logic [`RV_XLEN-1:0]      rs2_rdata_i,
    input  rv_decode_pkg::fwd_t      fwd_i,
    output logic [`RV_REG_AW-1:0]    rs1_addr_o,
    output logic [`RV_REG_AW-1:0]    rs2_addr_o,
    output logic                     hazard_o,
    output rv_decode_pkg::decoded_t  decoded_o
);
    import rv_decode_pkg::*;

    op_e                 op;
    format_e             fmt;
    logic                illegal;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] jump_target;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] second;
    logic                bubble;
    exc_t                exc;
    decoded_t            decoded_d;
    decoded_t            decoded_q;

    ////////////////////////////////////////////////////////////
    // Combinational units

    op_decoder u_op_decoder (
        .instr_i   (fetch_i.instr),
        .op_o      (op),
        .format_o  (fmt),
        .illegal_o (illegal)
    );

    imm_gen u_imm_gen (
        .instr_i       (fetch_i.instr),
        .pc_i          (fetch_i.pc),
        .format_i      (fmt),
        .imm_o         (imm),
        .jump_target_o (jump_target)
    );

    operand_forward u_operand_forward (
        .instr_i     (fetch_i.instr),
        .format_i    (fmt),
        .imm_i       (imm),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .fwd_i       (fwd_i),
        .exec_rd_i   (decoded_q.rd),   // Matches the execute result source
        .rs1_o       (rs1_data),
        .rs2_o       (rs2_data),
        .second_o    (second),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o)
    );

    hazard_unit u_hazard_unit (
        .clk            (clk),
        .reset_n        (reset_n),
        .enable_i       (enable_i),
        .flush_i        (flush_i),
        .instr_i        (fetch_i.instr),
        .format_i       (fmt),
        .illegal_i      (illegal),
        .pc_i           (fetch_i.pc[1:0]),
        .access_fault_i (fetch_i.access_fault),
        .hazard_o       (hazard_o),
        .bubble_o       (bubble),
        .exc_o          (exc)
    );

    ////////////////////////////////////////////////////////////
    // Output register

    always_comb begin
        decoded_d.op          = bubble ? NOP : op;   // Stall or flush inserts a NOP
        decoded_d.rd          = fetch_i.instr[11:7];
        decoded_d.rs1_data    = rs1_data;
        decoded_d.rs2_data    = rs2_data;
        decoded_d.second      = second;
        decoded_d.pc          = fetch_i.pc;
        decoded_d.jump_target = jump_target;
        decoded_d.killed      = flush_i;
        decoded_d.exc         = exc;                 // Already cleared by a flush
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            decoded_q <= '{op: NOP, default: '0};
        end else if (enable_i) begin
            decoded_q <= decoded_d;
        end
    end

    assign decoded_o = decoded_q;

endmodule

// ==== design/hazard_unit.sv ====
////////////////////////////////////////////////////////////
// Load-use and store-then-load hazards, exception flags
// Any store blocks the next load, addresses are not compared
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

module hazard_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   flush_i,
    input  logic [`RV_XLEN-1:0]    instr_i,
    input  rv_decode_pkg::format_e format_i,
    input  logic                   illegal_i,
    input  logic [1:0]             pc_i,           // Alignment bits of the pc only
    input  logic                   access_fault_i,
    output logic                   hazard_o,
    output logic                   bubble_o,
    output rv_decode_pkg::exc_t    exc_o
);
    import rv_decode_pkg::*;

    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic                  is_load;
    logic                  is_store;
    logic                  use_rs1;
    logic                  use_rs2;
    logic [`RV_REG_AW-1:0] locked_q;        // Destination of the load in execute
    logic                  store_pending_q;
    logic                  hazard_reg;
    logic                  hazard_mem;
    logic                  any_exc;

    assign rd       = instr_i[11:7];
    assign rs1      = instr_i[19:15];
    assign rs2      = instr_i[24:20];
    assign is_load  = (instr_i[6:2] == `RV_OPC_LOAD);
    assign is_store = (instr_i[6:2] == `RV_OPC_STORE);

    // SYSTEM falls under R and may stall needlessly
    assign use_rs1 = format_i inside {R_TYPE, B_TYPE, S_TYPE, I_TYPE};
    assign use_rs2 = format_i inside {R_TYPE, B_TYPE, S_TYPE};

    ////////////////////////////////////////////////////////////
    // Lock state

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_q        <= '0;
            store_pending_q <= 1'b0;
        end else if (enable_i) begin
            if (bubble_o) begin
                locked_q        <= '0;
                store_pending_q <= 1'b0;
            end else begin
                locked_q        <= is_load ? rd : '0;
                store_pending_q <= is_store;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Exceptions and hazard

    assign exc_o.illegal      = illegal_i && !flush_i;
    assign exc_o.misaligned   = (pc_i != 2'b00) && !flush_i;
    assign exc_o.access_fault = access_fault_i && !flush_i;
    assign any_exc            = exc_o.illegal || exc_o.misaligned || exc_o.access_fault;

    assign hazard_reg = (locked_q != '0) &&
                        ((use_rs1 && locked_q == rs1) || (use_rs2 && locked_q == rs2));
    assign hazard_mem = store_pending_q && is_load;

    // A trapping or flushed instruction never waits
    assign hazard_o = (hazard_reg || hazard_mem) && !flush_i && !any_exc;
    assign bubble_o = hazard_o || flush_i;

endmodule

// ==== design/operand_forward.sv ====
////////////////////////////////////////////////////////////
// Source operand forwarding and second operand select
// Execute result wins over retire, retire over register bank
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

module operand_forward (
    input  logic [`RV_XLEN-1:0]   instr_i,
    input  rv_decode_pkg::format_e format_i,
    input  logic [`RV_XLEN-1:0]   imm_i,
    input  logic [`RV_XLEN-1:0]   rs1_rdata_i,
    input  logic [`RV_XLEN-1:0]   rs2_rdata_i,
    input  rv_decode_pkg::fwd_t   fwd_i,
    input  logic [`RV_REG_AW-1:0] exec_rd_i,     // rd of the instruction now in execute
    output logic [`RV_XLEN-1:0]   rs1_o,
    output logic [`RV_XLEN-1:0]   rs2_o,
    output logic [`RV_XLEN-1:0]   second_o,
    output logic [`RV_REG_AW-1:0] rs1_addr_o,
    output logic [`RV_REG_AW-1:0] rs2_addr_o
);
    import rv_decode_pkg::*;

    // Priority select for one source register
    function automatic logic [`RV_XLEN-1:0] pick_source(
        input logic [`RV_REG_AW-1:0] addr,
        input logic [`RV_XLEN-1:0]   bank_data,
        input fwd_t                  fwd,
        input logic [`RV_REG_AW-1:0] exec_rd
    );
        logic [`RV_XLEN-1:0] data;
        if (fwd.exec_we && addr == exec_rd)
            data = fwd.exec_result;
        else if (fwd.wb_we && addr == fwd.wb_rd)
            data = fwd.wb_data;
        else
            data = bank_data;
        return data;
    endfunction

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign rs1_o = pick_source(rs1_addr_o, rs1_rdata_i, fwd_i, exec_rd_i);
    assign rs2_o = pick_source(rs2_addr_o, rs2_rdata_i, fwd_i, exec_rd_i);

    always_comb begin
        case (format_i)
            I_TYPE, S_TYPE, U_TYPE: second_o = imm_i;
            default:                second_o = rs2_o;  // R, B and J
        endcase
    end

endmodule

// ==== design/imm_gen.sv ====
////////////////////////////////////////////////////////////
// Immediate extraction and pc-relative jump target
// R format gives a zero immediate
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0]    instr_i,
    input  logic [`RV_XLEN-1:0]    pc_i,
    input  rv_decode_pkg::format_e format_i,
    output logic [`RV_XLEN-1:0]    imm_o,
    output logic [`RV_XLEN-1:0]    jump_target_o
);
    import rv_decode_pkg::*;

    logic [`RV_XLEN-1:0] imm_i_fmt;
    logic [`RV_XLEN-1:0] imm_s_fmt;
    logic [`RV_XLEN-1:0] imm_b_fmt;
    logic [`RV_XLEN-1:0] imm_u_fmt;
    logic [`RV_XLEN-1:0] imm_j_fmt;

    // Bit 31 is always the sign
    assign imm_i_fmt = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s_fmt = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b_fmt = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};
    assign imm_j_fmt = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

    always_comb begin
        case (format_i)
            I_TYPE:  imm_o = imm_i_fmt;
            S_TYPE:  imm_o = imm_s_fmt;
            B_TYPE:  imm_o = imm_b_fmt;
            U_TYPE:  imm_o = imm_u_fmt;
            J_TYPE:  imm_o = imm_j_fmt;
            default: imm_o = '0;
        endcase
    end

    assign jump_target_o = pc_i + imm_o;  // Branch and JAL target, execute picks the use

endmodule

// ==== design/op_decoder.sv ====
////////////////////////////////////////////////////////////
// RV32I operation decoder, purely combinational
// FENCE decodes to NOP, op is INVALID on any illegal word
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

module op_decoder (
    input  logic [`RV_XLEN-1:0]    instr_i,
    output rv_decode_pkg::op_e     op_o,
    output rv_decode_pkg::format_e format_o,
    output logic                   illegal_o
);
    import rv_decode_pkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       size_ok;    // Low bits 11 mark a 32-bit encoding
    op_e        op_branch;
    op_e        op_load;
    op_e        op_store;
    op_e        op_alu_imm;
    op_e        op_alu;
    op_e        op_system;
    op_e        op_major;

    assign opcode  = instr_i[6:2];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign size_ok = (instr_i[1:0] == 2'b11);

    ////////////////////////////////////////////////////////////
    // Sub-tables

    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift amounts need funct7 clear, except SRAI
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????_000: op_alu_imm = ADD;
            10'b0000000_001: op_alu_imm = SLL;
            10'b???????_010: op_alu_imm = SLT;
            10'b???????_011: op_alu_imm = SLTU;
            10'b???????_100: op_alu_imm = XOR;
            10'b0000000_101: op_alu_imm = SRL;
            10'b0100000_101: op_alu_imm = SRA;
            10'b???????_110: op_alu_imm = OR;
            10'b???????_111: op_alu_imm = AND;
            default:         op_alu_imm = INVALID;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_alu = ADD;
            10'b0100000_000: op_alu = SUB;
            10'b0000000_001: op_alu = SLL;
            10'b0000000_010: op_alu = SLT;
            10'b0000000_011: op_alu = SLTU;
            10'b0000000_100: op_alu = XOR;
            10'b0000000_101: op_alu = SRL;
            10'b0100000_101: op_alu = SRA;
            10'b0000000_110: op_alu = OR;
            10'b0000000_111: op_alu = AND;
            default:         op_alu = INVALID;
        endcase
    end

    // Privileged ops need every other field zero
    always_comb begin
        case (instr_i[31:7]) inside
            25'b0000000_00000_00000_000_00000: op_system = ECALL;
            25'b0000000_00001_00000_000_00000: op_system = EBREAK;
            25'b0011000_00010_00000_000_00000: op_system = MRET;
            25'b0001000_00101_00000_000_00000: op_system = WFI;
            25'b???????_?????_?????_001_?????: op_system = CSRRW;
            25'b???????_?????_?????_010_?????: op_system = CSRRS;
            25'b???????_?????_?????_011_?????: op_system = CSRRC;
            25'b???????_?????_?????_101_?????: op_system = CSRRWI;
            25'b???????_?????_?????_110_?????: op_system = CSRRSI;
            25'b???????_?????_?????_111_?????: op_system = CSRRCI;
            default:                           op_system = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Major opcode and format

    always_comb begin
        format_o = R_TYPE;
        case (opcode)
            `RV_OPC_LUI:      begin op_major = LUI;        format_o = U_TYPE; end
            `RV_OPC_AUIPC:    begin op_major = AUIPC;      format_o = U_TYPE; end
            `RV_OPC_JAL:      begin op_major = JAL;        format_o = J_TYPE; end
            `RV_OPC_JALR:     begin op_major = JALR;       format_o = I_TYPE; end
            `RV_OPC_BRANCH:   begin op_major = op_branch;  format_o = B_TYPE; end
            `RV_OPC_LOAD:     begin op_major = op_load;    format_o = I_TYPE; end
            `RV_OPC_STORE:    begin op_major = op_store;   format_o = S_TYPE; end
            `RV_OPC_OP_IMM:   begin op_major = op_alu_imm; format_o = I_TYPE; end
            `RV_OPC_OP:       op_major = op_alu;
            `RV_OPC_MISC_MEM: op_major = (funct3 == 3'b000) ? NOP : INVALID;  // FENCE
            `RV_OPC_SYSTEM:   op_major = op_system;
            default:          op_major = INVALID;
        endcase
    end

    assign op_o      = size_ok ? op_major : INVALID;
    assign illegal_o = !size_ok || (op_major == INVALID);

endmodule

// ==== design/rv_decode_pkg.sv ====
////////////////////////////////////////////////////////////
// Types shared by the decode stage and its neighbours
// Immediate forms of ALU ops decode to the register form
////////////////////////////////////////////////////////////

`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // Decoded operation
    typedef enum logic [5:0] {
        NOP,
        INVALID,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ECALL,
        EBREAK,
        MRET,
        WFI,
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    // From fetch
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
        logic                access_fault;
    } fetch_t;

    // Forwarding sources, execute result and retire writeback
    typedef struct packed {
        logic [`RV_XLEN-1:0]   exec_result;
        logic                  exec_we;
        logic [`RV_XLEN-1:0]   wb_data;
        logic [`RV_REG_AW-1:0] wb_rd;
        logic                  wb_we;
    } fwd_t;

    typedef struct packed {
        logic illegal;
        logic misaligned;
        logic access_fault;
    } exc_t;

    // Registered stage output towards execute
    typedef struct packed {
        op_e                   op;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   second;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   jump_target;
        logic                  killed;
        exc_t                  exc;
    } decoded_t;

endpackage

// ==== design/rv_decode_settings.svh ====
////////////////////////////////////////////////////////////
// Widths and major opcode values for the RV32I decode stage
// Opcodes are instr[6:2], the low two bits are checked apart
////////////////////////////////////////////////////////////

`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

`define RV_XLEN   32    // Data and address width
`define RV_REG_AW 5     // Register file address width

// Major opcodes, bits [6:2] of the instruction word
`define RV_OPC_LOAD     5'b00000
`define RV_OPC_STORE    5'b01000
`define RV_OPC_BRANCH   5'b11000
`define RV_OPC_JAL      5'b11011
`define RV_OPC_JALR     5'b11001
`define RV_OPC_OP_IMM   5'b00100
`define RV_OPC_OP       5'b01100
`define RV_OPC_LUI      5'b01101
`define RV_OPC_AUIPC    5'b00101
`define RV_OPC_MISC_MEM 5'b00011
`define RV_OPC_SYSTEM   5'b11100

`endif
